//--- filelist.f
rv_decode_pkg.sv
decode_if.sv
fetch_latch.sv
decoder.sv
imm_gen.sv
dispatch_stage.sv
decode_top.sv
tb_clkgen.sv
tb_decode_top.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f filelist.f \
    --top-module tb_decode_top -o sim_decode

output="$(./obj_dir/sim_decode 2>&1 || true)"
echo "$output"

if grep -q "^TEST PASSED$" <<< "$output"; then
    exit 0
else
    exit 1
fi

//--- tb_decode_top.sv
module tb_decode_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_TIMEOUT = 20;
    localparam int DRAIN_TIMEOUT = 20;
    localparam int RANDOM_COUNT  = 600;

    localparam logic [31:0] DIRECTED [10] = '{
        32'h402081b3,  // sub x3, x1, x2
        32'h4030d213,  // srai x4, x1, 3
        32'hfff00093,  // addi x1, x0, -1
        32'hfe112e23,  // sw x1, -4(x2)
        32'h800000ef,  // jal x1 with negative offset
        32'h123452b7,  // lui x5
        32'h00000033,  // add x0, x0, x0
        32'h02a5c633,  // div x12, x11, x10
        32'h00000063,  // beq is not supported
        32'h00008067   // jalr x0, 0(x1)
    };

    logic                          clk_i;
    logic                          rst_n_i;
    logic                          inst_valid_i;
    logic [31:0]                   inst_i;
    logic [31:0]                   pc_i;
    logic                          flush_i;
    logic                          disp_valid_o;
    logic [31:0]                   disp_pc_o;
    logic [31:0]                   disp_imm_o;
    rv_decode_pkg::decode_bundle_t act_bundle;

    rv_decode_pkg::decode_bundle_t exp_bundle_q [$];
    logic [31:0]                   exp_pc_q [$];
    logic [31:0]                   exp_imm_q [$];
    int                            exp_due_q [$];
    string                         exp_name_q [$];

    string cur_group;
    int    neg_cnt;
    logic  exp_valid;

    tb_clkgen clkgen_i (
        .clk_o   (clk_i),
        .rst_n_o (rst_n_i)
    );

    decode_top decode_top_i (
        .clk_i                (clk_i),
        .rst_n_i              (rst_n_i),
        .inst_valid_i         (inst_valid_i),
        .inst_i               (inst_i),
        .pc_i                 (pc_i),
        .flush_i              (flush_i),
        .disp_valid_o         (disp_valid_o),
        .disp_pc_o            (disp_pc_o),
        .disp_imm_o           (disp_imm_o),
        .disp_rs1_o           (act_bundle.rs1),
        .disp_rs2_o           (act_bundle.rs2),
        .disp_rd_o            (act_bundle.rd),
        .disp_imm_type_o      (act_bundle.imm_type),
        .disp_src_a_sel_o     (act_bundle.src_a_sel),
        .disp_src_b_sel_o     (act_bundle.src_b_sel),
        .disp_wr_reg_o        (act_bundle.wr_reg),
        .disp_uses_rs1_o      (act_bundle.uses_rs1),
        .disp_uses_rs2_o      (act_bundle.uses_rs2),
        .disp_illegal_o       (act_bundle.illegal),
        .disp_alu_op_o        (act_bundle.alu_op),
        .disp_rs_ent_o        (act_bundle.rs_ent),
        .disp_dmem_size_o     (act_bundle.dmem_size),
        .disp_dmem_type_o     (act_bundle.dmem_type),
        .disp_md_op_o         (act_bundle.md_op),
        .disp_md_in1_signed_o (act_bundle.md_in1_signed),
        .disp_md_in2_signed_o (act_bundle.md_in2_signed),
        .disp_md_out_sel_o    (act_bundle.md_out_sel)
    );

    function automatic rv_decode_pkg::alu_op_e ref_alu_op(input logic [2:0] f3,
                                                         input logic alt, input logic is_op);
        case (f3)
            3'b000:  return (is_op && alt) ? rv_decode_pkg::ALU_OP_SUB : rv_decode_pkg::ALU_OP_ADD;
            3'b001:  return rv_decode_pkg::ALU_OP_SLL;
            3'b010:  return rv_decode_pkg::ALU_OP_SLT;
            3'b011:  return rv_decode_pkg::ALU_OP_SLTU;
            3'b100:  return rv_decode_pkg::ALU_OP_XOR;
            3'b101:  return alt ? rv_decode_pkg::ALU_OP_SRA : rv_decode_pkg::ALU_OP_SRL;
            3'b110:  return rv_decode_pkg::ALU_OP_OR;
            default: return rv_decode_pkg::ALU_OP_AND;
        endcase
    endfunction

    // expected bundle as it leaves dispatch with x0 already dropped
    function automatic rv_decode_pkg::decode_bundle_t ref_decode(input logic [31:0] inst);
        rv_decode_pkg::decode_bundle_t b;
        logic [2:0]                    f3;
        logic [6:0]                    f7;
        f3 = inst[14:12];
        f7 = inst[31:25];
        b.rs1       = inst[19:15];
        b.rs2       = inst[24:20];
        b.rd        = inst[11:7];
        b.imm_type  = rv_decode_pkg::IMM_I;
        b.src_a_sel = rv_decode_pkg::SRC_A_RS1;
        b.src_b_sel = rv_decode_pkg::SRC_B_IMM;
        b.wr_reg    = 1'b1;
        b.uses_rs1  = 1'b0;
        b.uses_rs2  = 1'b0;
        b.illegal   = 1'b0;
        b.alu_op    = rv_decode_pkg::ALU_OP_ADD;
        b.rs_ent    = rv_decode_pkg::RS_ENT_ALU;
        b.dmem_size = {1'b0, f3[1:0]};
        b.dmem_type = f3;
        b.md_op     = f3[2] ? (f3[1] ? rv_decode_pkg::MD_OP_REM : rv_decode_pkg::MD_OP_DIV)
                            : rv_decode_pkg::MD_OP_MUL;
        b.md_in1_signed = (f3 == rv_decode_pkg::F3_MULH) || (f3 == rv_decode_pkg::F3_MULHSU)
                          || (f3 == rv_decode_pkg::F3_DIV) || (f3 == rv_decode_pkg::F3_REM);
        b.md_in2_signed = (f3 == rv_decode_pkg::F3_MULH) || (f3 == rv_decode_pkg::F3_DIV)
                          || (f3 == rv_decode_pkg::F3_REM);
        if (!f3[2] && f3 != rv_decode_pkg::F3_MUL) begin
            b.md_out_sel = rv_decode_pkg::MD_OUT_HI;
        end else if (f3[2] && f3[1]) begin
            b.md_out_sel = rv_decode_pkg::MD_OUT_REM;
        end else begin
            b.md_out_sel = rv_decode_pkg::MD_OUT_LO;
        end
        case (inst[6:0])
            rv_decode_pkg::OPC_LOAD: begin
                b.uses_rs1 = 1'b1;
                b.rs_ent   = rv_decode_pkg::RS_ENT_LDST;
            end
            rv_decode_pkg::OPC_STORE: begin
                b.imm_type = rv_decode_pkg::IMM_S;
                b.wr_reg   = 1'b0;
                b.uses_rs1 = 1'b1;
                b.uses_rs2 = 1'b1;
                b.rs_ent   = rv_decode_pkg::RS_ENT_LDST;
            end
            rv_decode_pkg::OPC_JAL: begin
                b.imm_type  = rv_decode_pkg::IMM_J;
                b.src_a_sel = rv_decode_pkg::SRC_A_PC;
                b.src_b_sel = rv_decode_pkg::SRC_B_FOUR;
                b.rs_ent    = rv_decode_pkg::RS_ENT_JAL;
            end
            rv_decode_pkg::OPC_JALR: begin
                b.src_a_sel = rv_decode_pkg::SRC_A_PC;
                b.src_b_sel = rv_decode_pkg::SRC_B_FOUR;
                b.uses_rs1  = 1'b1;
                b.rs_ent    = rv_decode_pkg::RS_ENT_JALR;
            end
            rv_decode_pkg::OPC_LUI: begin
                b.imm_type  = rv_decode_pkg::IMM_U;
                b.src_a_sel = rv_decode_pkg::SRC_A_ZERO;
            end
            rv_decode_pkg::OPC_AUIPC: begin
                b.imm_type  = rv_decode_pkg::IMM_U;
                b.src_a_sel = rv_decode_pkg::SRC_A_PC;
            end
            rv_decode_pkg::OPC_OP: begin
                b.src_b_sel = rv_decode_pkg::SRC_B_RS2;
                b.uses_rs1  = 1'b1;
                b.uses_rs2  = 1'b1;
                b.alu_op    = ref_alu_op(f3, f7[5], 1'b1);
                if (f7 == 7'b0000001) begin
                    b.rs_ent = f3[2] ? rv_decode_pkg::RS_ENT_DIV : rv_decode_pkg::RS_ENT_MUL;
                end
            end
            rv_decode_pkg::OPC_OP_IMM: begin
                b.uses_rs1 = 1'b1;
                b.alu_op   = ref_alu_op(f3, f7[5], 1'b0);
            end
            default: begin
                b.wr_reg  = 1'b0;
                b.illegal = 1'b1;
            end
        endcase
        if (b.rd == 5'd0) b.wr_reg = 1'b0;
        if (b.rs1 == 5'd0) b.uses_rs1 = 1'b0;
        if (b.rs2 == 5'd0) b.uses_rs2 = 1'b0;
        return b;
    endfunction

    function automatic logic [31:0] ref_imm(input logic [31:0] inst);
        case (inst[6:0])
            rv_decode_pkg::OPC_STORE: return 32'($signed({inst[31:25], inst[11:7]}));
            rv_decode_pkg::OPC_JAL:
                return 32'($signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));
            rv_decode_pkg::OPC_LUI, rv_decode_pkg::OPC_AUIPC: return {inst[31:12], 12'h000};
            default: return 32'($signed(inst[31:20]));
        endcase
    endfunction

    // opcodes biased toward the supported set plus some x0 fields
    function automatic logic [31:0] rand_inst();
        logic [31:0] w;
        logic [31:0] r;
        int unsigned kind;
        w    = $urandom;
        r    = $urandom;
        kind = $urandom_range(11, 0);
        case (kind)
            0:  w[6:0] = rv_decode_pkg::OPC_LOAD;
            1:  w[6:0] = rv_decode_pkg::OPC_STORE;
            2:  w[6:0] = rv_decode_pkg::OPC_JAL;
            3:  w[6:0] = rv_decode_pkg::OPC_JALR;
            4:  w[6:0] = rv_decode_pkg::OPC_LUI;
            5:  w[6:0] = rv_decode_pkg::OPC_AUIPC;
            6:  w[6:0] = rv_decode_pkg::OPC_OP;
            7:  w[6:0] = rv_decode_pkg::OPC_OP_IMM;
            8:  w[6:0] = rv_decode_pkg::OPC_OP;
            9:  w[6:0] = 7'b1100011;  // branch
            10: w[6:0] = r[9] ? 7'b1110011 : 7'b0001111;  // system or fence
            default: ;
        endcase
        if (kind == 8) begin
            w[31:25] = 7'b0000001;
        end else if (kind == 6 || kind == 7) begin
            if (r[11:10] == 2'd0) w[31:25] = 7'h00;
            if (r[11:10] == 2'd1) w[31:25] = 7'h20;
        end
        if (r[2:0] == 3'd0) w[11:7] = 5'd0;
        if (r[5:3] == 3'd0) w[19:15] = 5'd0;
        if (r[8:6] == 3'd0) w[24:20] = 5'd0;
        return w;
    endfunction

    task automatic report_fail(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "decode testbench stopped");
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_fail($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            report_fail($sformatf("[FAIL] %s: expected %08h, actual %08h", name, exp, act));
        end
    endtask

    task automatic check_bundle(input string name, input rv_decode_pkg::decode_bundle_t exp,
                                input rv_decode_pkg::decode_bundle_t act);
        if (act !== exp) begin
            report_fail($sformatf("[FAIL] %s bundle: expected %h, actual %h", name, exp, act));
        end
    endtask

    // compare at the falling edge where outputs are settled
    always @(negedge clk_i) begin
        neg_cnt++;
        if (rst_n_i) begin
            exp_valid = 1'b0;
            if (exp_due_q.size() > 0) begin
                exp_valid = (exp_due_q[0] == neg_cnt);
            end
            check_bit($sformatf("disp_valid_o at cycle %0d", neg_cnt), exp_valid, disp_valid_o);
            if (exp_valid) begin
                void'(exp_due_q.pop_front());
                check_bundle(exp_name_q[0], exp_bundle_q.pop_front(), act_bundle);
                check_word({exp_name_q[0], " pc"}, exp_pc_q.pop_front(), disp_pc_o);
                check_word({exp_name_q[0], " imm"}, exp_imm_q.pop_front(), disp_imm_o);
                void'(exp_name_q.pop_front());
            end
            if (flush_i) begin
                exp_bundle_q.delete();  // kills the one still in the fetch latch
                exp_pc_q.delete();
                exp_imm_q.delete();
                exp_due_q.delete();
                exp_name_q.delete();
            end else if (inst_valid_i) begin
                exp_bundle_q.push_back(ref_decode(inst_i));
                exp_pc_q.push_back(pc_i);
                exp_imm_q.push_back(ref_imm(inst_i));
                exp_due_q.push_back(neg_cnt + 2);
                exp_name_q.push_back($sformatf("%s inst %08h pc %08h", cur_group, inst_i, pc_i));
            end
        end
    end

    task automatic drive_inst(input string group, input logic [31:0] inst, input logic [31:0] pc);
        @(posedge clk_i);
        cur_group = group;
        inst_valid_i <= 1'b1;
        inst_i       <= inst;
        pc_i         <= pc;
        flush_i      <= 1'b0;
    endtask

    task automatic drive_flush(input logic [31:0] inst, input logic [31:0] pc);
        @(posedge clk_i);
        cur_group = "flush";
        inst_valid_i <= 1'b1;  // entering together with the flush
        inst_i       <= inst;
        pc_i         <= pc;
        flush_i      <= 1'b1;
    endtask

    task automatic drive_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk_i);
            inst_valid_i <= 1'b0;
            flush_i      <= 1'b0;
        end
    endtask

    task automatic wait_drain();
        int cnt;
        cnt = 0;
        while (exp_due_q.size() != 0) begin
            @(posedge clk_i);
            cnt++;
            if (cnt > DRAIN_TIMEOUT) begin
                report_fail("timeout: decoded instructions never left the dispatch stage");
            end
        end
    endtask

    initial begin
        int          cnt;
        int unsigned sel;
        logic [31:0] pc;
        void'($urandom(32'h7476_1d31));
        inst_valid_i = 1'b0;
        inst_i       = '0;
        pc_i         = '0;
        flush_i      = 1'b0;
        cur_group    = "reset";
        neg_cnt      = 0;
        pc           = 32'h0000_1000;
        cnt          = 0;
        while (!rst_n_i) begin
            @(posedge clk_i);
            cnt++;
            if (cnt > RESET_TIMEOUT) begin
                report_fail("timeout: reset was never released");
            end
        end
        drive_idle(6);  // nothing may come out
        for (int i = 0; i < 10; i++) begin
            drive_inst("directed", DIRECTED[i], pc);
            pc = pc + 4;
        end
        drive_idle(1);
        wait_drain();
        drive_inst("flush order", 32'h00308093, 32'h0000_2000);
        drive_inst("flush order", 32'h00410113, 32'h0000_2004);
        drive_flush(32'h00518193, 32'h0000_2008);
        drive_inst("after flush", 32'h00620213, 32'h0000_200c);
        drive_inst("after flush", 32'h00728293, 32'h0000_2010);
        drive_idle(1);
        wait_drain();
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            sel = $urandom_range(15, 0);
            if (sel == 0) begin
                drive_flush(rand_inst(), pc);
            end else if (sel < 3) begin
                drive_idle(1);
            end else begin
                drive_inst("random", rand_inst(), pc);
            end
            pc = pc + 4;
        end
        drive_idle(1);
        wait_drain();
        drive_idle(3);
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- tb_clkgen.sv
module tb_clkgen (
    output logic clk_o,
    output logic rst_n_o
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;  // 20 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

//--- decode_top.sv
module decode_top (
    input  logic                                      clk_i,
    input  logic                                      rst_n_i,
    input  logic                                      inst_valid_i,
    input  logic [rv_decode_pkg::XLEN-1:0]            inst_i,
    input  logic [rv_decode_pkg::XLEN-1:0]            pc_i,
    input  logic                                      flush_i,
    output logic                                      disp_valid_o,
    output logic [rv_decode_pkg::XLEN-1:0]            disp_pc_o,
    output logic [rv_decode_pkg::XLEN-1:0]            disp_imm_o,
    output logic [rv_decode_pkg::REG_SEL-1:0]         disp_rs1_o,
    output logic [rv_decode_pkg::REG_SEL-1:0]         disp_rs2_o,
    output logic [rv_decode_pkg::REG_SEL-1:0]         disp_rd_o,
    output rv_decode_pkg::imm_type_e                  disp_imm_type_o,
    output rv_decode_pkg::src_a_sel_e                 disp_src_a_sel_o,
    output rv_decode_pkg::src_b_sel_e                 disp_src_b_sel_o,
    output logic                                      disp_wr_reg_o,
    output logic                                      disp_uses_rs1_o,
    output logic                                      disp_uses_rs2_o,
    output logic                                      disp_illegal_o,
    output rv_decode_pkg::alu_op_e                    disp_alu_op_o,
    output rv_decode_pkg::rs_ent_e                    disp_rs_ent_o,
    output logic [2:0]                                disp_dmem_size_o,
    output logic [2:0]                                disp_dmem_type_o,
    output rv_decode_pkg::md_op_e                     disp_md_op_o,
    output logic                                      disp_md_in1_signed_o,
    output logic                                      disp_md_in2_signed_o,
    output rv_decode_pkg::md_out_sel_e                disp_md_out_sel_o
);

    logic                           f_valid;
    logic [rv_decode_pkg::XLEN-1:0] f_inst;
    logic [rv_decode_pkg::XLEN-1:0] f_pc;
    logic [rv_decode_pkg::XLEN-1:0] f_imm;
    rv_decode_pkg::decode_bundle_t  f_bundle;
    rv_decode_pkg::decode_bundle_t  d_bundle;

    decode_if dec_if ();

    fetch_latch fetch_latch_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .flush_i      (flush_i),
        .valid_o      (f_valid),
        .inst_o       (f_inst),
        .pc_o         (f_pc)
    );

    decoder decoder_i (
        .inst_i   (f_inst),
        .bundle_o (f_bundle)
    );

    imm_gen imm_gen_i (
        .inst_i     (f_inst),
        .imm_type_i (f_bundle.imm_type),
        .imm_o      (f_imm)
    );

    assign dec_if.valid  = f_valid;
    assign dec_if.pc     = f_pc;
    assign dec_if.imm    = f_imm;
    assign dec_if.bundle = f_bundle;

    dispatch_stage dispatch_stage_i (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .flush_i  (flush_i),
        .dec      (dec_if.dst),
        .valid_o  (disp_valid_o),
        .pc_o     (disp_pc_o),
        .imm_o    (disp_imm_o),
        .bundle_o (d_bundle)
    );

    assign disp_rs1_o           = d_bundle.rs1;
    assign disp_rs2_o           = d_bundle.rs2;
    assign disp_rd_o            = d_bundle.rd;
    assign disp_imm_type_o      = d_bundle.imm_type;
    assign disp_src_a_sel_o     = d_bundle.src_a_sel;
    assign disp_src_b_sel_o     = d_bundle.src_b_sel;
    assign disp_wr_reg_o        = d_bundle.wr_reg;
    assign disp_uses_rs1_o      = d_bundle.uses_rs1;
    assign disp_uses_rs2_o      = d_bundle.uses_rs2;
    assign disp_illegal_o       = d_bundle.illegal;
    assign disp_alu_op_o        = d_bundle.alu_op;
    assign disp_rs_ent_o        = d_bundle.rs_ent;
    assign disp_dmem_size_o     = d_bundle.dmem_size;
    assign disp_dmem_type_o     = d_bundle.dmem_type;
    assign disp_md_op_o         = d_bundle.md_op;
    assign disp_md_in1_signed_o = d_bundle.md_in1_signed;
    assign disp_md_in2_signed_o = d_bundle.md_in2_signed;
    assign disp_md_out_sel_o    = d_bundle.md_out_sel;

endmodule

//--- dispatch_stage.sv
module dispatch_stage (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           flush_i,
    decode_if.dst                          dec,
    output logic                           valid_o,
    output logic [rv_decode_pkg::XLEN-1:0] pc_o,
    output logic [rv_decode_pkg::XLEN-1:0] imm_o,
    output rv_decode_pkg::decode_bundle_t  bundle_o
);

    rv_decode_pkg::decode_bundle_t bundle_d;

    // x0 is never renamed, so drop its write and uses
    always_comb begin
        bundle_d          = dec.bundle;
        bundle_d.wr_reg   = dec.bundle.wr_reg & (dec.bundle.rd != '0);
        bundle_d.uses_rs1 = dec.bundle.uses_rs1 & (dec.bundle.rs1 != '0);
        bundle_d.uses_rs2 = dec.bundle.uses_rs2 & (dec.bundle.rs2 != '0);
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= dec.valid & ~flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (dec.valid) begin
            pc_o     <= dec.pc;
            imm_o    <= dec.imm;
            bundle_o <= bundle_d;
        end
    end

endmodule

//--- imm_gen.sv
module imm_gen (
    input  logic [rv_decode_pkg::XLEN-1:0] inst_i,
    input  rv_decode_pkg::imm_type_e       imm_type_i,
    output logic [rv_decode_pkg::XLEN-1:0] imm_o
);

    logic sign;

    assign sign = inst_i[31];

    always_comb begin
        case (imm_type_i)
            rv_decode_pkg::IMM_S: begin
                imm_o = {{20{sign}}, inst_i[31:25], inst_i[11:7]};
            end
            rv_decode_pkg::IMM_J: begin
                imm_o = {{12{sign}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
            end
            rv_decode_pkg::IMM_U: begin
                imm_o = {inst_i[31:12], 12'b0};  // low half zero
            end
            default: begin
                imm_o = {{20{sign}}, inst_i[31:20]};
            end
        endcase
    end

endmodule

//--- decoder.sv
module decoder (
    input  logic [rv_decode_pkg::XLEN-1:0] inst_i,
    output rv_decode_pkg::decode_bundle_t  bundle_o
);

    logic [6:0]                  opcode;
    logic [2:0]                  funct3;
    logic [6:0]                  funct7;
    rv_decode_pkg::alu_op_e      alu_arith;
    rv_decode_pkg::rs_ent_e      md_ent;
    rv_decode_pkg::md_op_e       md_op;
    logic                        md_s1;
    logic                        md_s2;
    rv_decode_pkg::md_out_sel_e  md_out;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    always_comb begin
        case (funct3)
            rv_decode_pkg::F3_ADD_SUB: alu_arith = (opcode == rv_decode_pkg::OPC_OP && funct7[5])
                                                   ? rv_decode_pkg::ALU_OP_SUB
                                                   : rv_decode_pkg::ALU_OP_ADD;
            rv_decode_pkg::F3_SLL:     alu_arith = rv_decode_pkg::ALU_OP_SLL;
            rv_decode_pkg::F3_SLT:     alu_arith = rv_decode_pkg::ALU_OP_SLT;
            rv_decode_pkg::F3_SLTU:    alu_arith = rv_decode_pkg::ALU_OP_SLTU;
            rv_decode_pkg::F3_XOR:     alu_arith = rv_decode_pkg::ALU_OP_XOR;
            rv_decode_pkg::F3_SRL_SRA: alu_arith = funct7[5] ? rv_decode_pkg::ALU_OP_SRA
                                                             : rv_decode_pkg::ALU_OP_SRL;
            rv_decode_pkg::F3_OR:      alu_arith = rv_decode_pkg::ALU_OP_OR;
            default:                   alu_arith = rv_decode_pkg::ALU_OP_AND;
        endcase
    end

    // mul/div fields always follow funct3, entry only matters for M ops
    always_comb begin
        md_ent = rv_decode_pkg::RS_ENT_DIV;
        md_op  = rv_decode_pkg::MD_OP_MUL;
        md_s1  = 1'b0;
        md_s2  = 1'b0;
        md_out = rv_decode_pkg::MD_OUT_LO;
        case (funct3)
            rv_decode_pkg::F3_MUL: begin
                md_ent = rv_decode_pkg::RS_ENT_MUL;
            end
            rv_decode_pkg::F3_MULH: begin
                md_ent = rv_decode_pkg::RS_ENT_MUL;
                md_s1  = 1'b1;
                md_s2  = 1'b1;
                md_out = rv_decode_pkg::MD_OUT_HI;
            end
            rv_decode_pkg::F3_MULHSU: begin
                md_ent = rv_decode_pkg::RS_ENT_MUL;
                md_s1  = 1'b1;  // rs1 signed, rs2 unsigned
                md_out = rv_decode_pkg::MD_OUT_HI;
            end
            rv_decode_pkg::F3_MULHU: begin
                md_ent = rv_decode_pkg::RS_ENT_MUL;
                md_out = rv_decode_pkg::MD_OUT_HI;
            end
            rv_decode_pkg::F3_DIV: begin
                md_op = rv_decode_pkg::MD_OP_DIV;
                md_s1 = 1'b1;
                md_s2 = 1'b1;
            end
            rv_decode_pkg::F3_DIVU: begin
                md_op = rv_decode_pkg::MD_OP_DIV;
            end
            rv_decode_pkg::F3_REM: begin
                md_op  = rv_decode_pkg::MD_OP_REM;
                md_s1  = 1'b1;
                md_s2  = 1'b1;
                md_out = rv_decode_pkg::MD_OUT_REM;
            end
            default: begin  // REMU
                md_op  = rv_decode_pkg::MD_OP_REM;
                md_out = rv_decode_pkg::MD_OUT_REM;
            end
        endcase
    end

    always_comb begin
        bundle_o.rs1           = inst_i[19:15];
        bundle_o.rs2           = inst_i[24:20];
        bundle_o.rd            = inst_i[11:7];
        bundle_o.imm_type      = rv_decode_pkg::IMM_I;
        bundle_o.src_a_sel     = rv_decode_pkg::SRC_A_RS1;
        bundle_o.src_b_sel     = rv_decode_pkg::SRC_B_IMM;
        bundle_o.wr_reg        = 1'b1;
        bundle_o.uses_rs1      = 1'b0;
        bundle_o.uses_rs2      = 1'b0;
        bundle_o.illegal       = 1'b0;
        bundle_o.alu_op        = rv_decode_pkg::ALU_OP_ADD;
        bundle_o.rs_ent        = rv_decode_pkg::RS_ENT_ALU;
        bundle_o.dmem_size     = {1'b0, funct3[1:0]};
        bundle_o.dmem_type     = funct3;
        bundle_o.md_op         = md_op;
        bundle_o.md_in1_signed = md_s1;
        bundle_o.md_in2_signed = md_s2;
        bundle_o.md_out_sel    = md_out;
        case (opcode)
            rv_decode_pkg::OPC_LOAD: begin
                bundle_o.uses_rs1 = 1'b1;
                bundle_o.rs_ent   = rv_decode_pkg::RS_ENT_LDST;
            end
            rv_decode_pkg::OPC_STORE: begin
                bundle_o.imm_type = rv_decode_pkg::IMM_S;
                bundle_o.wr_reg   = 1'b0;
                bundle_o.uses_rs1 = 1'b1;
                bundle_o.uses_rs2 = 1'b1;
                bundle_o.rs_ent   = rv_decode_pkg::RS_ENT_LDST;
            end
            rv_decode_pkg::OPC_JAL: begin
                bundle_o.imm_type  = rv_decode_pkg::IMM_J;
                bundle_o.src_a_sel = rv_decode_pkg::SRC_A_PC;  // link value pc + 4
                bundle_o.src_b_sel = rv_decode_pkg::SRC_B_FOUR;
                bundle_o.rs_ent    = rv_decode_pkg::RS_ENT_JAL;
            end
            rv_decode_pkg::OPC_JALR: begin
                bundle_o.src_a_sel = rv_decode_pkg::SRC_A_PC;
                bundle_o.src_b_sel = rv_decode_pkg::SRC_B_FOUR;
                bundle_o.uses_rs1  = 1'b1;  // target base
                bundle_o.rs_ent    = rv_decode_pkg::RS_ENT_JALR;
            end
            rv_decode_pkg::OPC_LUI: begin
                bundle_o.imm_type  = rv_decode_pkg::IMM_U;
                bundle_o.src_a_sel = rv_decode_pkg::SRC_A_ZERO;
            end
            rv_decode_pkg::OPC_AUIPC: begin
                bundle_o.imm_type  = rv_decode_pkg::IMM_U;
                bundle_o.src_a_sel = rv_decode_pkg::SRC_A_PC;
            end
            rv_decode_pkg::OPC_OP: begin
                bundle_o.src_b_sel = rv_decode_pkg::SRC_B_RS2;
                bundle_o.uses_rs1  = 1'b1;
                bundle_o.uses_rs2  = 1'b1;
                bundle_o.alu_op    = alu_arith;
                if (funct7 == rv_decode_pkg::F7_MULDIV) begin
                    bundle_o.rs_ent = md_ent;
                end
            end
            rv_decode_pkg::OPC_OP_IMM: begin
                bundle_o.uses_rs1 = 1'b1;
                bundle_o.alu_op   = alu_arith;
            end
            default: begin
                bundle_o.wr_reg  = 1'b0;
                bundle_o.illegal = 1'b1;  // branch, system, fence and unknown
            end
        endcase
    end

endmodule

//--- fetch_latch.sv
module fetch_latch (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           inst_valid_i,
    input  logic [rv_decode_pkg::XLEN-1:0] inst_i,
    input  logic [rv_decode_pkg::XLEN-1:0] pc_i,
    input  logic                           flush_i,
    output logic                           valid_o,
    output logic [rv_decode_pkg::XLEN-1:0] inst_o,
    output logic [rv_decode_pkg::XLEN-1:0] pc_o
);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= inst_valid_i & ~flush_i;  // same-cycle entry dropped on flush
        end
    end

    always_ff @(posedge clk_i) begin
        if (inst_valid_i) begin
            inst_o <= inst_i;
            pc_o   <= pc_i;
        end
    end

endmodule

//--- decode_if.sv
interface decode_if;

    logic                               valid;
    logic [rv_decode_pkg::XLEN-1:0]     pc;
    logic [rv_decode_pkg::XLEN-1:0]     imm;
    rv_decode_pkg::decode_bundle_t      bundle;  // combinational decode of f_inst

    modport src (
        output valid,
        output pc,
        output imm,
        output bundle
    );

    modport dst (
        input valid,
        input pc,
        input imm,
        input bundle
    );

endinterface

//--- rv_decode_pkg.sv
package rv_decode_pkg;

    localparam int XLEN    = 32;
    localparam int REG_SEL = 5;

    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    localparam logic [6:0] F7_MULDIV = 7'b0000001;  // M extension marker on OP

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_MUL    = 3'b000;
    localparam logic [2:0] F3_MULH   = 3'b001;
    localparam logic [2:0] F3_MULHSU = 3'b010;
    localparam logic [2:0] F3_MULHU  = 3'b011;
    localparam logic [2:0] F3_DIV    = 3'b100;
    localparam logic [2:0] F3_DIVU   = 3'b101;
    localparam logic [2:0] F3_REM    = 3'b110;
    localparam logic [2:0] F3_REMU   = 3'b111;

    typedef enum logic [1:0] {IMM_I, IMM_S, IMM_J, IMM_U} imm_type_e;

    typedef enum logic [1:0] {SRC_A_RS1, SRC_A_PC, SRC_A_ZERO} src_a_sel_e;
    typedef enum logic [1:0] {SRC_B_RS2, SRC_B_IMM, SRC_B_FOUR} src_b_sel_e;

    typedef enum logic [3:0] {
        ALU_OP_ADD, ALU_OP_SUB, ALU_OP_SLL, ALU_OP_SLT, ALU_OP_SLTU,
        ALU_OP_XOR, ALU_OP_SRL, ALU_OP_SRA, ALU_OP_OR, ALU_OP_AND
    } alu_op_e;

    typedef enum logic [2:0] {
        RS_ENT_ALU, RS_ENT_LDST, RS_ENT_JAL, RS_ENT_JALR, RS_ENT_MUL, RS_ENT_DIV
    } rs_ent_e;

    typedef enum logic [1:0] {MD_OP_MUL, MD_OP_DIV, MD_OP_REM} md_op_e;
    typedef enum logic [1:0] {MD_OUT_LO, MD_OUT_HI, MD_OUT_REM} md_out_sel_e;

    typedef struct packed {
        logic [REG_SEL-1:0] rs1;
        logic [REG_SEL-1:0] rs2;
        logic [REG_SEL-1:0] rd;
        imm_type_e          imm_type;
        src_a_sel_e         src_a_sel;
        src_b_sel_e         src_b_sel;
        logic               wr_reg;
        logic               uses_rs1;
        logic               uses_rs2;
        logic               illegal;
        alu_op_e            alu_op;
        rs_ent_e            rs_ent;
        logic [2:0]         dmem_size;
        logic [2:0]         dmem_type;  // funct3 of load/store
        md_op_e             md_op;
        logic               md_in1_signed;
        logic               md_in2_signed;
        md_out_sel_e        md_out_sel;
    } decode_bundle_t;

endpackage
